// File: source/nn_mem_pkg.sv
package nn_mem_pkg;

	// Layer configuration for the hidden layer memory controller
	localparam int P  = 16; // Neurons in the previous layer
	localparam int FO = 2;  // Fan-out of each previous layer neuron
	localparam int Z  = 4;  // Memories in one collection
	localparam int L  = 3;  // Layers in the whole network
	localparam int H  = 1;  // Index of this hidden layer
	localparam int EC = 2;  // Extra clocks appended to every training cycle

	// The memories hold words of this width while the controller never touches data
	localparam int WIDTH = 12;

	// Clocks per training cycle and the part of it that carries real work
	localparam int CPC        = P*FO/Z + EC;
	localparam int EFF_CYCLES = CPC - EC;

	// Activation collections needed to keep values alive until update
	localparam int COLL = 2*(L-H) - 1;

	// A part is a group of Z/FO memories written together in one clock
	localparam int MEMS_PER_PART = Z/FO;

	localparam int LOG_PBYZ  = (P == Z) ? 1 : $clog2(P/Z); // Cells per memory need this many bits
	localparam int LOG_Z     = (Z == 1) ? 1 : $clog2(Z);   // Select width of each Z to 1 mux
	localparam int PART_BITS = (FO == 1) ? 1 : $clog2(FO);
	localparam int PTR_BITS  = (COLL == 1) ? 1 : $clog2(COLL);
	localparam int IDX_BITS  = $clog2(CPC);
	localparam int MIDX_BITS = $clog2(P); // One index names a neuron of the previous layer

	typedef logic [IDX_BITS-1:0]  cycle_idx_t;
	typedef logic [LOG_PBYZ-1:0]  mem_addr_t;
	typedef logic [PTR_BITS-1:0]  coll_ptr_t;
	typedef logic [Z-1:0]         we_vec_t;     // One write enable per memory of a collection

	typedef mem_addr_t [Z-1:0]                 addr_vec_t;    // Memory m uses element m
	typedef logic [Z-1:0][LOG_Z-1:0]           muxsel_vec_t;
	typedef logic [Z-1:0][MIDX_BITS-1:0]       mem_idx_vec_t; // Interleaver output, one per lane

	// All collection pointers move together at the end of a training cycle
	typedef struct packed {
		coll_ptr_t rff; // Activation collection read for feed-forward of the next layer
		coll_ptr_t wff; // Activation collection being written by this layer
		coll_ptr_t rup; // Activation collection read for the weight update
		logic      rbp; // Delta collection read for backpropagation to the previous layer
	} coll_ptrs_t;

	// Every activation/adot memory gets an address and a write enable
	typedef struct packed {
		addr_vec_t [COLL-1:0] addr;
		we_vec_t   [COLL-1:0] we;
	} act_ctl_t;

	// Both delta collections are dual ported for the read-modify-write
	typedef struct packed {
		addr_vec_t [1:0] addr_a;
		we_vec_t   [1:0] we_a;
		addr_vec_t [1:0] addr_b;
		we_vec_t   [1:0] we_b;
	} del_ctl_t;

	// Part that is served in the clock given by a cycle index
	function automatic int cycle_part(input cycle_idx_t ci);
		cycle_part = int'(ci) % FO;
	endfunction

	// Part that memory m belongs to
	function automatic int mem_part(input int m);
		mem_part = m / MEMS_PER_PART;
	endfunction

	// Cell address for sequential access, the cycle index with its part bits dropped
	function automatic mem_addr_t seq_addr(input cycle_idx_t ci);
		seq_addr = mem_addr_t'(int'(ci) / FO);
	endfunction

endpackage

// File: source/coll_pointers.sv
`timescale 1ns/1ps

module coll_pointers (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  nn_mem_pkg::cycle_idx_t cycle_index_i, // Clock position inside the training cycle
	output nn_mem_pkg::coll_ptrs_t ptrs_o          // Pointers valid for the whole cycle
);

	import nn_mem_pkg::*;

	coll_ptrs_t ptrs_q;
	logic       cycle_end; // Last clock of the training cycle

	// Move one collection ahead and wrap after the last one
	function automatic coll_ptr_t next_coll(input coll_ptr_t cur);
		next_coll = (cur == coll_ptr_t'(COLL - 1)) ? '0 : cur + 1'b1;
	endfunction

	assign cycle_end = (cycle_index_i == cycle_idx_t'(CPC - 1));

	// The three activation pointers start one collection apart and keep that spacing
	// The layer ahead reads rff while this layer fills wff and the update reads rup
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ptrs_q.rff <= coll_ptr_t'(0);
			ptrs_q.wff <= coll_ptr_t'(1 % COLL);
			ptrs_q.rup <= coll_ptr_t'(2 % COLL);
			ptrs_q.rbp <= 1'b0;
		end else if (cycle_end) begin
			ptrs_q.rff <= next_coll(ptrs_q.rff); // What was written becomes readable for FF
			ptrs_q.wff <= next_coll(ptrs_q.wff);
			ptrs_q.rup <= next_coll(ptrs_q.rup);
			ptrs_q.rbp <= ~ptrs_q.rbp; // Accumulated deltas are now read for BP
		end
	end

	// New values show up in the clock where the cycle index is back at 0
	assign ptrs_o = ptrs_q;

endmodule

// File: source/read_addr_decoder.sv
`timescale 1ns/1ps

module read_addr_decoder (
	input  logic                     clk,
	input  logic                     rst_n_i,
	input  nn_mem_pkg::mem_idx_vec_t memory_index_i, // Neuron indices from the interleaver
	output nn_mem_pkg::addr_vec_t    raddr_o,        // Cell to read in each memory
	output nn_mem_pkg::muxsel_vec_t  muxsel_o        // Lane routing after the memory read
);

	import nn_mem_pkg::*;

	muxsel_vec_t muxsel_q;

	// Neuron n lives in memory n mod Z at cell n div Z
	genvar gv_m;
	generate
		for (gv_m = 0; gv_m < Z; gv_m++) begin : g_lane
			if (P == Z) begin : g_one_cell
				assign raddr_o[gv_m] = '0; // Every memory holds a single cell
			end else begin : g_cells
				// High bits pick the cell and the low bits name the memory
				assign raddr_o[gv_m] = memory_index_i[gv_m][MIDX_BITS-1:LOG_Z];
			end
		end
	endgenerate

	// Lane m takes the word of memory m
	// Registered so that the select lines up with the read data one clock later
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			muxsel_q <= '0;
		end else begin
			for (int m = 0; m < Z; m++) begin
				muxsel_q[m] <= LOG_Z'(m);
			end
		end
	end

	assign muxsel_o = muxsel_q;

endmodule

// File: source/act_coll_ctr.sv
`timescale 1ns/1ps

module act_coll_ctr (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  nn_mem_pkg::cycle_idx_t cycle_index_i,
	input  nn_mem_pkg::addr_vec_t  raddr_i,   // Decoded interleaver read addresses
	input  nn_mem_pkg::coll_ptrs_t ptrs_i,
	output nn_mem_pkg::act_ctl_t   act_ctl_o, // Address and write enable of every memory
	output nn_mem_pkg::coll_ptr_t  rff_ptr_o, // FF read pointer aligned with the read data
	output nn_mem_pkg::coll_ptr_t  rup_ptr_o  // UP read pointer aligned with the read data
);

	import nn_mem_pkg::*;

	cycle_idx_t cycle_d1;
	cycle_idx_t cycle_d2;  // The previous layer delivers its first values two clocks late
	coll_ptr_t  rff_q;
	coll_ptr_t  rup_q;
	mem_addr_t  wff_addr;  // Cell written in every memory of the wFF collection
	logic       wr_window; // Incoming values are real in this clock
	int         wr_part;   // Part whose memories take the incoming values

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			cycle_d1 <= '0;
			cycle_d2 <= '0;
			rff_q    <= '0;
			rup_q    <= '0;
		end else begin
			cycle_d1 <= cycle_index_i;
			cycle_d2 <= cycle_d1;
			rff_q    <= ptrs_i.rff; // Memory read takes one clock
			rup_q    <= ptrs_i.rup;
		end
	end

	assign wff_addr  = seq_addr(cycle_d2); // Same cell for FO clocks in a row, one per part
	assign wr_window = rst_n_i && (cycle_d2 < cycle_idx_t'(EFF_CYCLES));
	assign wr_part   = cycle_part(cycle_d2);

	// Each clock fills one cell in the Z/FO memories of one part
	// After FO clocks every memory of the collection holds one more cell
	always_comb begin
		for (int c = 0; c < COLL; c++) begin
			if (ptrs_i.wff == coll_ptr_t'(c)) begin
				act_ctl_o.addr[c] = {Z{wff_addr}}; // Collection being filled
			end else begin
				act_ctl_o.addr[c] = raddr_i; // Reads are free to use the other collections
			end
			for (int m = 0; m < Z; m++) begin
				act_ctl_o.we[c][m] = wr_window &&
					(ptrs_i.wff == coll_ptr_t'(c)) &&
					(mem_part(m) == wr_part);
			end
		end
	end

	assign rff_ptr_o = rff_q;
	assign rup_ptr_o = rup_q;

endmodule

// File: source/del_coll_ctr.sv
`timescale 1ns/1ps

module del_coll_ctr (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  nn_mem_pkg::cycle_idx_t cycle_index_i,
	input  nn_mem_pkg::addr_vec_t  raddr_i,          // Interleaved addresses for the RMW
	input  nn_mem_pkg::coll_ptrs_t ptrs_i,
	output nn_mem_pkg::del_ctl_t   del_ctl_o,        // Port A and B control of both collections
	output nn_mem_pkg::cycle_idx_t cycle_index_dly_o // Lets the datapath line up its write data
);

	import nn_mem_pkg::*;

	cycle_idx_t cycle_d1;
	addr_vec_t  raddr_d1;  // Read address of the RMW, reused one clock later for the write
	mem_addr_t  seq_now;   // Sequential cell read from the BP collection this clock
	mem_addr_t  seq_d1;    // The same cell one clock later when it gets cleared
	logic       a_window;  // Clocks where the RMW write on port A is allowed
	logic       b_window;  // Clocks where the clear on port B is allowed
	int         clr_part;  // Part whose memories are cleared this clock

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			cycle_d1 <= '0;
			raddr_d1 <= '0;
			seq_d1   <= '0;
		end else begin
			cycle_d1 <= cycle_index_i;
			raddr_d1 <= raddr_i;
			seq_d1   <= seq_now;
		end
	end

	assign seq_now = seq_addr(cycle_index_i);

	// Nothing has been read yet in clock 0 so no write can follow
	// Past EFF_CYCLES the last read has already been written back
	assign a_window = rst_n_i &&
		(cycle_index_i != '0) &&
		(cycle_index_i <= cycle_idx_t'(EFF_CYCLES));

	// The clear trails the sequential read by one clock
	assign b_window = rst_n_i && (cycle_d1 < cycle_idx_t'(EFF_CYCLES));
	assign clr_part = cycle_part(cycle_d1);

	// The rBP collection is read in order on port A for BP of the previous layer
	// Port B zeroes each cell right behind the read because this collection
	// starts accumulating from scratch in the next training cycle
	// The other collection reads partial deltas on port B and writes the sums on port A
	always_comb begin
		for (int c = 0; c < 2; c++) begin
			if (ptrs_i.rbp == 1'(c)) begin
				del_ctl_o.addr_a[c] = {Z{seq_now}};
				del_ctl_o.addr_b[c] = {Z{seq_d1}};
			end else begin
				del_ctl_o.addr_a[c] = raddr_d1; // Write back where was read one clock before
				del_ctl_o.addr_b[c] = raddr_i;
			end
			for (int m = 0; m < Z; m++) begin
				del_ctl_o.we_a[c][m] = a_window && (ptrs_i.rbp != 1'(c));
				del_ctl_o.we_b[c][m] = b_window &&
					(ptrs_i.rbp == 1'(c)) &&
					(mem_part(m) == clr_part); // Cleared part by part, like the write of act
			end
		end
	end

	// Port A and port B of one collection are never written in the same clock
	// because each port only writes for one of the two pointer values

	assign cycle_index_dly_o = cycle_d1;

endmodule

// File: source/hidden_layer_mem_ctr.sv
`timescale 1ns/1ps

module hidden_layer_mem_ctr (
	input  logic                     clk,
	input  logic                     rst_n_i,
	input  nn_mem_pkg::cycle_idx_t   cycle_index_i,     // Counts 0 to CPC-1 and wraps
	input  nn_mem_pkg::mem_idx_vec_t memory_index_i,    // New neuron indices every clock
	output nn_mem_pkg::act_ctl_t     act_ctl_o,         // Activation and adot memories
	output nn_mem_pkg::del_ctl_t     del_ctl_o,         // Delta memories
	output nn_mem_pkg::cycle_idx_t   cycle_index_dly_o, // Cycle index one clock late
	output nn_mem_pkg::coll_ptr_t    act_rff_ptr_o,
	output nn_mem_pkg::coll_ptr_t    act_rup_ptr_o,
	output logic                     del_rbp_ptr_o,
	output nn_mem_pkg::muxsel_vec_t  muxsel_o
);

	import nn_mem_pkg::*;

	coll_ptrs_t ptrs;  // Collection pointers shared by both collection controllers
	addr_vec_t  raddr; // Decoded read addresses shared by both collection controllers

	// Advances all collection pointers at the end of every training cycle
	coll_pointers coll_pointers_inst (
		.clk,
		.rst_n_i,
		.cycle_index_i,
		.ptrs_o(ptrs)
	);

	// Turns the neuron indices into cell addresses and mux selects
	read_addr_decoder read_addr_decoder_inst (
		.clk,
		.rst_n_i,
		.memory_index_i,
		.raddr_o(raddr),
		.muxsel_o
	);

	act_coll_ctr act_coll_ctr_inst (
		.clk,
		.rst_n_i,
		.cycle_index_i,
		.raddr_i(raddr),
		.ptrs_i(ptrs),
		.act_ctl_o,
		.rff_ptr_o(act_rff_ptr_o),
		.rup_ptr_o(act_rup_ptr_o)
	);

	del_coll_ctr del_coll_ctr_inst (
		.clk,
		.rst_n_i,
		.cycle_index_i,
		.raddr_i(raddr),
		.ptrs_i(ptrs),
		.del_ctl_o,
		.cycle_index_dly_o
	);

	// The BP pointer goes out undelayed since the delta read uses it in the same clock
	assign del_rbp_ptr_o = ptrs.rbp;

endmodule

// File: tests/hidden_layer_mem_ctr_tb.sv
`timescale 1ns/1ps

module hidden_layer_mem_ctr_tb;

	import nn_mem_pkg::*;

	localparam int CLK_PERIOD  = 10;
	localparam int RUN_CYCLES  = 30; // Training cycles driven after reset
	localparam int WDOG_CYCLES = 40; // Watchdog budget in training cycles
	localparam int TIMEOUT_NS  = WDOG_CYCLES * CPC * CLK_PERIOD + 20 * CLK_PERIOD;
	localparam int PART_SIZE   = Z / FO; // Memories that share one part

	logic         clk;
	logic         rst_n_i;
	cycle_idx_t   cycle_index_i;
	mem_idx_vec_t memory_index_i;
	act_ctl_t     act_ctl_o;
	del_ctl_t     del_ctl_o;
	cycle_idx_t   cycle_index_dly_o;
	coll_ptr_t    act_rff_ptr_o;
	coll_ptr_t    act_rup_ptr_o;
	logic         del_rbp_ptr_o;
	muxsel_vec_t  muxsel_o;

	integer seed; // State of $random
	int     count; // Next cycle index to drive

	// Reference model state, updated on the same edges as the DUT
	int          m_rff;
	int          m_wff;
	int          m_rup;
	logic        m_rbp;
	int          m_rff_q;      // Exported FF pointer, one clock late
	int          m_rup_q;      // Exported UP pointer, one clock late
	cycle_idx_t  m_d1;         // Cycle index one clock late
	cycle_idx_t  m_d2;         // Cycle index two clocks late
	addr_vec_t   m_raddr_d1;   // Read address one clock late
	mem_addr_t   m_seq_d1;     // Sequential cell one clock late
	muxsel_vec_t m_muxsel;
	bit          started = 1'b0; // Model holds known state after the first edge

	int errors = 0;
	int checks = 0;

	hidden_layer_mem_ctr hidden_layer_mem_ctr_inst (
		.clk,
		.rst_n_i,
		.cycle_index_i,
		.memory_index_i,
		.act_ctl_o,
		.del_ctl_o,
		.cycle_index_dly_o,
		.act_rff_ptr_o,
		.act_rup_ptr_o,
		.del_rbp_ptr_o,
		.muxsel_o
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Neuron n sits in memory n mod Z, at cell n div Z
	function automatic addr_vec_t decode_raddr(input mem_idx_vec_t idx);
		addr_vec_t r;
		for (int m = 0; m < Z; m++) begin
			r[m] = mem_addr_t'(int'(idx[m]) / Z);
		end
		return r;
	endfunction

	// One named comparison, counted and reported on mismatch
	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		assert (actual === expected)
			else begin
				errors++;
				$display("Error in %s at %0t ns: expected %0h, actual %0h",
					name, $time, expected, actual);
			end
	endtask

	// Reference model registers, they see the inputs of the previous clock like the DUT
	always @(posedge clk) begin
		started <= 1'b1;
		if (!rst_n_i) begin
			m_rff      <= 0;
			m_wff      <= 1;
			m_rup      <= 2;
			m_rbp      <= 1'b0;
			m_rff_q    <= 0;
			m_rup_q    <= 0;
			m_d1       <= '0;
			m_d2       <= '0;
			m_raddr_d1 <= '0;
			m_seq_d1   <= '0;
			m_muxsel   <= '0;
		end else begin
			m_d1       <= cycle_index_i;
			m_d2       <= m_d1;
			m_rff_q    <= m_rff;
			m_rup_q    <= m_rup;
			m_raddr_d1 <= decode_raddr(memory_index_i);
			m_seq_d1   <= mem_addr_t'(int'(cycle_index_i) / FO);
			for (int m = 0; m < Z; m++) begin
				m_muxsel[m] <= LOG_Z'(m); // Memory m routes to lane m
			end
			if (int'(cycle_index_i) == CPC - 1) begin
				m_rff <= (m_rff + 1) % COLL; // All activation pointers step together
				m_wff <= (m_wff + 1) % COLL;
				m_rup <= (m_rup + 1) % COLL;
				m_rbp <= ~m_rbp;
			end
		end
	end

	// Builds the expected outputs and compares them all
	task automatic run_checks();
		act_ctl_t  exp_act;
		del_ctl_t  exp_del;
		addr_vec_t raddr_now;
		int        d2_part;
		int        d1_part;
		raddr_now = decode_raddr(memory_index_i);
		d2_part   = int'(m_d2) % FO; // Part being written into activations
		d1_part   = int'(m_d1) % FO; // Part being cleared in the BP deltas

		for (int c = 0; c < COLL; c++) begin
			for (int m = 0; m < Z; m++) begin
				exp_act.we[c][m] = rst_n_i && (int'(m_d2) < EFF_CYCLES) &&
					(c == m_wff) && (m / PART_SIZE == d2_part);
				if (c == m_wff) begin
					exp_act.addr[c][m] = mem_addr_t'(int'(m_d2) / FO);
				end else begin
					exp_act.addr[c][m] = raddr_now[m];
				end
			end
		end

		for (int c = 0; c < 2; c++) begin
			for (int m = 0; m < Z; m++) begin
				if (c == int'(m_rbp)) begin
					// Sequential read on A, clear one clock behind on B
					exp_del.addr_a[c][m] = mem_addr_t'(int'(cycle_index_i) / FO);
					exp_del.addr_b[c][m] = m_seq_d1;
					exp_del.we_a[c][m]   = 1'b0;
					exp_del.we_b[c][m]   = rst_n_i && (int'(m_d1) < EFF_CYCLES) &&
						(m / PART_SIZE == d1_part);
				end else begin
					exp_del.addr_a[c][m] = m_raddr_d1[m]; // Write back of the RMW
					exp_del.addr_b[c][m] = raddr_now[m];  // Read of the RMW
					exp_del.we_a[c][m]   = rst_n_i && (cycle_index_i != '0) &&
						(int'(cycle_index_i) <= EFF_CYCLES);
					exp_del.we_b[c][m]   = 1'b0;
				end
			end
		end

		for (int c = 0; c < COLL; c++) begin
			check_value($sformatf("act_we[%0d]", c), exp_act.we[c], act_ctl_o.we[c]);
			check_value($sformatf("act_addr[%0d]", c), exp_act.addr[c], act_ctl_o.addr[c]);
		end
		for (int c = 0; c < 2; c++) begin
			check_value($sformatf("del_we_a[%0d]", c), exp_del.we_a[c], del_ctl_o.we_a[c]);
			check_value($sformatf("del_we_b[%0d]", c), exp_del.we_b[c], del_ctl_o.we_b[c]);
			check_value($sformatf("del_addr_a[%0d]", c), exp_del.addr_a[c],
				del_ctl_o.addr_a[c]);
			check_value($sformatf("del_addr_b[%0d]", c), exp_del.addr_b[c],
				del_ctl_o.addr_b[c]);
			checks++;
			assert ((del_ctl_o.we_a[c] & del_ctl_o.we_b[c]) == '0)
				else begin
					errors++;
					$display("Delta collection %0d has both ports written at %0t ns",
						c, $time);
				end
		end

		check_value("act_rff_ptr", m_rff_q, act_rff_ptr_o);
		check_value("act_rup_ptr", m_rup_q, act_rup_ptr_o);
		check_value("del_rbp_ptr", m_rbp, del_rbp_ptr_o);
		check_value("cycle_index_dly", m_d1, cycle_index_dly_o);
		check_value("muxsel", m_muxsel, muxsel_o);
	endtask

	// Outputs are settled half a clock after the inputs change
	always @(negedge clk) begin
		if (started) begin
			run_checks();
		end
	end

	initial begin
		seed           = 16903;
		rst_n_i        = 1'b0;
		cycle_index_i  = '0;
		memory_index_i = '0;

		// Reset spans two rising edges while the indices already change
		repeat (2) begin
			@(posedge clk);
			memory_index_i <= mem_idx_vec_t'($random(seed));
		end
		rst_n_i       <= 1'b1;
		cycle_index_i <= '0;
		count = 1;

		repeat (RUN_CYCLES * CPC) begin
			@(posedge clk);
			cycle_index_i  <= cycle_idx_t'(count);
			memory_index_i <= mem_idx_vec_t'($random(seed)); // New interleaver set every clock
			count = (count + 1) % CPC;
		end

		@(negedge clk); // Last set of inputs gets its check here
		@(posedge clk); // That check has completed by this edge
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// Stops a run that outlives the stimulus by a wide margin
	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired after %0d ns before the stimulus completed", TIMEOUT_NS);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		$display("Finished with errors");
		$finish;
	end

endmodule

// File: hidden_layer_mem_ctr.f
source/nn_mem_pkg.sv
source/coll_pointers.sv
source/read_addr_decoder.sv
source/act_coll_ctr.sv
source/del_coll_ctr.sv
source/hidden_layer_mem_ctr.sv
tests/hidden_layer_mem_ctr_tb.sv
